// File: Makefile
VERILATOR ?= verilator
TOP       ?= cache_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= build.f
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Simulation passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# Output goes to the terminal and is searched for the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: build.f
+incdir+include
src/cache_pkg.sv
src/way_if.sv
src/plru_tree.sv
src/way_arrays.sv
src/cache_ctrl.sv
src/cache_datapath.sv
src/cache_top.sv
tests/mem_model.sv
tests/cache_tb.sv

// File: include/cache_consts.svh
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// Cache geometry
`define CACHE_WAYS  4
`define CACHE_SETS  16
`define LINE_BITS   256
`define WORD_BITS   32

// Address split into tag, index and offset
`define TAG_BITS    23
`define INDEX_BITS  4
`define OFFSET_BITS 5

`endif

// File: src/cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cpu_rmask,
    input  logic [3:0]        cpu_wmask,
    input  logic              hit,
    input  logic              dirty_victim,
    input  logic              mem_resp,
    output cache_pkg::state_t state,
    output logic              mem_read,
    output logic              mem_write
);
    import cache_pkg::*;

    state_t next_state;
    logic   cpu_req;

    assign cpu_req = cpu_rmask || (cpu_wmask != 4'b0);

    always_comb begin
        next_state = state;
        case (state)
            idle_s: begin
                if (cpu_req) begin
                    next_state = compare_tag_s;
                end
            end
            compare_tag_s: begin
                if (hit) begin
                    next_state = idle_s;
                end else if (dirty_victim) begin
                    next_state = writeback_s;
                end else begin
                    next_state = allocate_s;
                end
            end
            writeback_s: begin
                if (mem_resp) begin
                    next_state = allocate_s;
                end
            end
            allocate_s: begin
                // Line is written on this edge and the compare runs again
                if (mem_resp) begin
                    next_state = compare_tag_s;
                end
            end
            default: begin
                next_state = idle_s;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= idle_s;
        end else begin
            state <= next_state;
        end
    end

    // Memory request levels
    assign mem_read  = (state == allocate_s);
    assign mem_write = (state == writeback_s);

endmodule

// File: src/cache_datapath.sv
`timescale 1ns/1ps
`include "cache_consts.svh"

module cache_datapath (
    input  cache_pkg::word_t  cpu_addr,
    input  logic              cpu_rmask,
    input  logic [3:0]        cpu_wmask,
    input  cache_pkg::word_t  cpu_wdata,
    input  cache_pkg::state_t state,
    input  cache_pkg::plru_t  plru_bits,
    input  cache_pkg::line_t  mem_rdata,
    input  logic              mem_resp,
    output cache_pkg::word_t  cpu_rdata,
    output logic              cpu_resp,
    output logic              hit,
    output logic              dirty_victim,
    output logic              update_plru,
    output cache_pkg::way_t   hit_way,
    output cache_pkg::word_t  mem_addr,
    output cache_pkg::line_t  mem_wdata,
    way_if.datapath           ways
);
    import cache_pkg::*;

    tag_t    tag;
    index_t  index;
    offset_t offset;
    offset_t word_base;
    way_t    victim_way;
    tag_t    victim_tag;
    logic    cpu_req;
    logic    is_write;
    logic    any_match;
    logic    have_invalid;

    assign tag       = cpu_addr[`WORD_BITS-1 -: `TAG_BITS];
    assign index     = cpu_addr[`OFFSET_BITS +: `INDEX_BITS];
    assign offset    = cpu_addr[`OFFSET_BITS-1:0];
    assign word_base = {offset[4:2], 2'b00};
    assign cpu_req   = cpu_rmask || (cpu_wmask != 4'b0);
    assign is_write  = (cpu_wmask != 4'b0);

    // Tag compare across the valid ways
    always_comb begin
        any_match = 1'b0;
        hit_way   = '0;
        for (int w = `CACHE_WAYS-1; w >= 0; w--) begin
            if (ways.valid[w] && ways.tag_word[w][`TAG_BITS-1:0] == tag) begin
                any_match = 1'b1;
                hit_way   = way_t'(w);
            end
        end
    end

    assign hit         = cpu_req && any_match;
    assign cpu_resp    = (state == compare_tag_s) && hit;
    assign update_plru = cpu_resp;
    assign cpu_rdata   = ways.line[hit_way][{word_base, 3'b000} +: `WORD_BITS];

    // Lowest invalid way first, then the PLRU tree
    always_comb begin
        have_invalid = 1'b0;
        victim_way   = plru_bits[0] ? {1'b1, plru_bits[2]} : {1'b0, plru_bits[1]};
        for (int w = `CACHE_WAYS-1; w >= 0; w--) begin
            if (!ways.valid[w]) begin
                have_invalid = 1'b1;
                victim_way   = way_t'(w);
            end
        end
    end

    assign victim_tag   = ways.tag_word[victim_way][`TAG_BITS-1:0];
    assign dirty_victim = !have_invalid && ways.tag_word[victim_way][`TAG_BITS];
    assign mem_wdata    = ways.line[victim_way];
    assign mem_addr     = (state == writeback_s) ? {victim_tag, index, 5'b0} : {tag, index, 5'b0};

    // Array write requests
    always_comb begin
        ways.index = index;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            ways.valid_we_n[w] = 1'b1;
            ways.valid_wr[w]   = 1'b1;
            ways.tag_we_n[w]   = 1'b1;
            ways.tag_wr[w]     = {1'b0, tag};
            ways.line_we_n[w]  = 1'b1;
            ways.line_be[w]    = '1;
            ways.line_wr[w]    = mem_rdata;
        end
        if (cpu_resp && is_write) begin
            // Merge the store and mark the line dirty
            ways.tag_we_n[hit_way]  = 1'b0;
            ways.tag_wr[hit_way]    = {1'b1, tag};
            ways.line_we_n[hit_way] = 1'b0;
            ways.line_be[hit_way]   = (`LINE_BITS/8)'(cpu_wmask) << word_base;
            ways.line_wr[hit_way]   = line_t'(cpu_wdata) << {word_base, 3'b000};
        end else if (state == allocate_s && mem_resp) begin
            ways.valid_we_n[victim_way] = 1'b0;
            ways.tag_we_n[victim_way]   = 1'b0;
            ways.line_we_n[victim_way]  = 1'b0;
        end
    end

endmodule

// File: src/cache_pkg.sv
package cache_pkg;

`include "cache_consts.svh"

    typedef logic [`WORD_BITS-1:0]   word_t;
    typedef logic [`LINE_BITS-1:0]   line_t;
    typedef logic [`TAG_BITS-1:0]    tag_t;
    // Dirty bit sits above the tag
    typedef logic [`TAG_BITS:0]      tag_word_t;
    typedef logic [`INDEX_BITS-1:0]  index_t;
    typedef logic [`OFFSET_BITS-1:0] offset_t;
    typedef logic [1:0]              way_t;
    typedef logic [2:0]              plru_t;

    typedef enum logic [1:0] {
        idle_s,
        compare_tag_s,
        writeback_s,
        allocate_s
    } state_t;

endpackage

// File: src/cache_top.sv
`timescale 1ns/1ps

module cache_top (
    input  logic             clk,
    input  logic             rst_n,
    input  cache_pkg::word_t cpu_addr,
    input  logic             cpu_rmask,
    input  logic [3:0]       cpu_wmask,
    input  cache_pkg::word_t cpu_wdata,
    output cache_pkg::word_t cpu_rdata,
    output logic             cpu_resp,
    output cache_pkg::word_t mem_addr,
    output logic             mem_read,
    output logic             mem_write,
    output cache_pkg::line_t mem_wdata,
    input  cache_pkg::line_t mem_rdata,
    input  logic             mem_resp
);
    import cache_pkg::*;

    state_t state;
    plru_t  plru_bits;
    way_t   hit_way;
    logic   hit;
    logic   dirty_victim;
    logic   update_plru;

    way_if ways ();

    cache_ctrl i_cache_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .cpu_rmask    (cpu_rmask),
        .cpu_wmask    (cpu_wmask),
        .hit          (hit),
        .dirty_victim (dirty_victim),
        .mem_resp     (mem_resp),
        .state        (state),
        .mem_read     (mem_read),
        .mem_write    (mem_write)
    );

    cache_datapath i_cache_datapath (
        .cpu_addr     (cpu_addr),
        .cpu_rmask    (cpu_rmask),
        .cpu_wmask    (cpu_wmask),
        .cpu_wdata    (cpu_wdata),
        .state        (state),
        .plru_bits    (plru_bits),
        .mem_rdata    (mem_rdata),
        .mem_resp     (mem_resp),
        .cpu_rdata    (cpu_rdata),
        .cpu_resp     (cpu_resp),
        .hit          (hit),
        .dirty_victim (dirty_victim),
        .update_plru  (update_plru),
        .hit_way      (hit_way),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .ways         (ways.datapath)
    );

    way_arrays i_way_arrays (
        .clk   (clk),
        .rst_n (rst_n),
        .ways  (ways.arrays)
    );

    plru_tree i_plru_tree (
        .clk         (clk),
        .rst_n       (rst_n),
        .index       (ways.index),
        .update_plru (update_plru),
        .hit_way     (hit_way),
        .plru_bits   (plru_bits)
    );

endmodule

// File: src/plru_tree.sv
`timescale 1ns/1ps
`include "cache_consts.svh"

module plru_tree (
    input  logic              clk,
    input  logic              rst_n,
    input  cache_pkg::index_t index,
    input  logic              update_plru,
    input  cache_pkg::way_t   hit_way,
    output cache_pkg::plru_t  plru_bits
);
    import cache_pkg::*;

    plru_t plru_q [`CACHE_SETS];
    plru_t plru_next;

    // Point the path away from the way just used
    always_comb begin
        plru_next = plru_q[index];
        if (!hit_way[1]) begin
            plru_next[0] = 1'b1;
            plru_next[1] = ~hit_way[0];
        end else begin
            plru_next[0] = 1'b0;
            plru_next[2] = ~hit_way[0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < `CACHE_SETS; s++) begin
                plru_q[s] <= '0;
            end
        end else if (update_plru) begin
            plru_q[index] <= plru_next;
        end
    end

    assign plru_bits = plru_q[index];

endmodule

// File: src/way_arrays.sv
`timescale 1ns/1ps
`include "cache_consts.svh"

module way_arrays (
    input logic clk,
    input logic rst_n,
    way_if.arrays ways
);
    import cache_pkg::*;

    logic      valid_q [`CACHE_WAYS][`CACHE_SETS];
    tag_word_t tag_q   [`CACHE_WAYS][`CACHE_SETS];
    line_t     line_q  [`CACHE_WAYS][`CACHE_SETS];

    // Combinational read of the indexed set
    always_comb begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            ways.valid[w]    = valid_q[w][ways.index];
            ways.tag_word[w] = tag_q[w][ways.index];
            ways.line[w]     = line_q[w][ways.index];
        end
    end

    // Valid bits
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                for (int s = 0; s < `CACHE_SETS; s++) begin
                    valid_q[w][s] <= 1'b0;
                end
            end
        end else begin
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                if (!ways.valid_we_n[w]) begin
                    valid_q[w][ways.index] <= ways.valid_wr[w];
                end
            end
        end
    end

    // Tags and lines
    always_ff @(posedge clk) begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (!ways.tag_we_n[w]) begin
                tag_q[w][ways.index] <= ways.tag_wr[w];
            end
            if (!ways.line_we_n[w]) begin
                for (int b = 0; b < `LINE_BITS/8; b++) begin
                    if (ways.line_be[w][b]) begin
                        line_q[w][ways.index][8*b +: 8] <= ways.line_wr[w][8*b +: 8];
                    end
                end
            end
        end
    end

endmodule

// File: src/way_if.sv
`timescale 1ns/1ps
`include "cache_consts.svh"

interface way_if;
    import cache_pkg::*;

    // Entries read at the current index
    logic      valid    [`CACHE_WAYS];
    tag_word_t tag_word [`CACHE_WAYS];
    line_t     line     [`CACHE_WAYS];

    // Write requests with active-low enables
    index_t                  index;
    logic                    valid_we_n [`CACHE_WAYS];
    logic                    valid_wr   [`CACHE_WAYS];
    logic                    tag_we_n   [`CACHE_WAYS];
    tag_word_t               tag_wr     [`CACHE_WAYS];
    logic                    line_we_n  [`CACHE_WAYS];
    logic [`LINE_BITS/8-1:0] line_be    [`CACHE_WAYS];
    line_t                   line_wr    [`CACHE_WAYS];

    modport arrays (
        output valid, tag_word, line,
        input  index, valid_we_n, valid_wr, tag_we_n, tag_wr, line_we_n, line_be, line_wr
    );

    modport datapath (
        input  valid, tag_word, line,
        output index, valid_we_n, valid_wr, tag_we_n, tag_wr, line_we_n, line_be, line_wr
    );

endinterface

// File: tests/cache_tb.sv
`timescale 1ns/1ps
`include "cache_consts.svh"

module cache_tb;
    import cache_pkg::*;

    localparam int num_reqs    = 400;
    localparam int cycle_limit = num_reqs * 30;

    logic       clk;
    logic       rst_n;
    word_t      cpu_addr;
    logic       cpu_rmask;
    logic [3:0] cpu_wmask;
    word_t      cpu_wdata;
    word_t      cpu_rdata;
    logic       cpu_resp;
    word_t      mem_addr;
    logic       mem_read;
    logic       mem_write;
    line_t      mem_wdata;
    line_t      mem_rdata;
    logic       mem_resp;
    int         write_count;
    word_t      last_wr_addr;
    line_t      last_wr_line;

    int errors;
    int checks;
    int cycle_count = 0;

    // CPU view of memory and the directory the cache should hold
    logic [7:0] image [word_t];
    logic       m_valid [`CACHE_SETS][`CACHE_WAYS];
    tag_t       m_tag   [`CACHE_SETS][`CACHE_WAYS];
    logic       m_dirty [`CACHE_SETS][`CACHE_WAYS];
    plru_t      m_plru  [`CACHE_SETS];

    cache_top i_cache_top (.*);

    mem_model i_mem_model (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout after %0d cycles, a request never got its response", cycle_count);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic check(string name, logic [255:0] got, logic [255:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    function automatic logic [31:0] init_word(word_t a);
        return (a * 32'h9e37_79b1) ^ 32'h5a3c_0f69;
    endfunction

    function automatic logic [7:0] read_byte(word_t a);
        logic [31:0] w;
        if (image.exists(a)) begin
            return image[a];
        end
        w = init_word({a[31:2], 2'b00});
        return w[8*a[1:0] +: 8];
    endfunction

    function automatic line_t model_line(word_t line_addr);
        line_t l;
        for (int b = 0; b < 32; b++) begin
            l[8*b +: 8] = read_byte(line_addr + word_t'(b));
        end
        return l;
    endfunction

    function automatic way_t pick_victim(index_t s);
        way_t v;
        logic found;
        found = 1'b0;
        v     = '0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (!found && !m_valid[s][w]) begin
                found = 1'b1;
                v     = way_t'(w);
            end
        end
        // Bit 0 of the tree picks the half
        if (!found) begin
            if (m_plru[s][0]) begin
                v = {1'b1, m_plru[s][2]};
            end else begin
                v = {1'b0, m_plru[s][1]};
            end
        end
        return v;
    endfunction

    task automatic touch(index_t s, way_t w);
        if (w < 2) begin
            m_plru[s][0] = 1'b1;
            m_plru[s][1] = (w == 0);
        end else begin
            m_plru[s][0] = 1'b0;
            m_plru[s][2] = (w == 2);
        end
    endtask

    task automatic do_request(word_t addr, logic is_write, logic [3:0] wmask, word_t wdata);
        index_t s;
        tag_t   t;
        way_t   w;
        logic   pred_hit;
        logic   expect_wb;
        word_t  wb_addr;
        line_t  wb_line;
        word_t  exp_rdata;
        int     wc_before;
        int     cycles;
        logic   saw_read;
        logic   saw_write;

        s         = addr[`OFFSET_BITS +: `INDEX_BITS];
        t         = addr[31 -: `TAG_BITS];
        pred_hit  = 1'b0;
        expect_wb = 1'b0;
        w         = '0;
        wb_addr   = '0;
        wb_line   = '0;
        for (int i = 0; i < `CACHE_WAYS; i++) begin
            if (m_valid[s][i] && m_tag[s][i] == t) begin
                pred_hit = 1'b1;
                w        = way_t'(i);
            end
        end
        if (!pred_hit) begin
            w         = pick_victim(s);
            expect_wb = m_valid[s][w] && m_dirty[s][w];
            wb_addr   = {m_tag[s][w], s, 5'b0};
            wb_line   = model_line(wb_addr);
            m_valid[s][w] = 1'b1;
            m_tag[s][w]   = t;
            m_dirty[s][w] = 1'b0;
        end
        // The refilled line hits on the retry, so the path is touched either way
        touch(s, w);
        exp_rdata = {read_byte(addr + 3), read_byte(addr + 2), read_byte(addr + 1),
                     read_byte(addr)};
        wc_before = write_count;

        @(posedge clk);
        #2;
        cpu_addr  = addr;
        cpu_rmask = !is_write;
        cpu_wmask = is_write ? wmask : 4'b0;
        cpu_wdata = wdata;
        cycles    = 0;
        saw_read  = 1'b0;
        saw_write = 1'b0;
        do begin
            @(negedge clk);
            cycles++;
            saw_read  |= mem_read;
            saw_write |= mem_write;
        end while (!cpu_resp);

        if (pred_hit) begin
            check("cpu_resp latency", cycles, 2);
            check("mem_read", saw_read, 0);
        end else begin
            check("mem_read", saw_read, 1);
        end
        check("mem_write", saw_write, expect_wb);
        check("write count", write_count - wc_before, expect_wb);
        if (expect_wb) begin
            check("mem_addr", last_wr_addr, wb_addr);
            check("mem_wdata", last_wr_line, wb_line);
        end
        if (is_write) begin
            m_dirty[s][w] = 1'b1;
            for (int b = 0; b < 4; b++) begin
                if (wmask[b]) begin
                    image[addr + word_t'(b)] = wdata[8*b +: 8];
                end
            end
        end else begin
            check("cpu_rdata", cpu_rdata, exp_rdata);
        end

        @(posedge clk);
        #2;
        cpu_rmask = 1'b0;
        cpu_wmask = 4'b0;
    endtask

    initial begin
        word_t      addr;
        index_t     s;
        tag_t       t;
        logic       is_write;
        logic [3:0] wmask;

        void'($urandom(32'h4802));
        errors    = 0;
        checks    = 0;
        rst_n     = 1'b0;
        cpu_addr  = '0;
        cpu_rmask = 1'b0;
        cpu_wmask = 4'b0;
        cpu_wdata = '0;
        for (int i = 0; i < `CACHE_SETS; i++) begin
            m_plru[i] = '0;
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                m_valid[i][w] = 1'b0;
                m_dirty[i][w] = 1'b0;
                m_tag[i][w]   = '0;
            end
        end

        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;

        // Quiet outputs before the first request
        repeat (3) begin
            @(negedge clk);
            check("cpu_resp", cpu_resp, 0);
            check("mem_read", mem_read, 0);
            check("mem_write", mem_write, 0);
        end

        // Six tags over two sets keep evictions frequent
        for (int n = 0; n < num_reqs; n++) begin
            s        = ($urandom_range(1) != 0) ? 4'd9 : 4'd2;
            t        = 23'h1200 + 23'($urandom_range(5));
            addr     = {t, s, 3'($urandom_range(7)), 2'b00};
            is_write = ($urandom_range(99) < 40);
            wmask    = 4'($urandom_range(15, 1));
            do_request(addr, is_write, wmask, $urandom);
        end

        $display("Requests: %0d, checks: %0d, errors: %0d", num_reqs, checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: tests/mem_model.sv
`timescale 1ns/1ps

module mem_model (
    input  logic             clk,
    input  cache_pkg::word_t mem_addr,
    input  logic             mem_read,
    input  logic             mem_write,
    input  cache_pkg::line_t mem_wdata,
    output cache_pkg::line_t mem_rdata,
    output logic             mem_resp,
    output int               write_count,
    output cache_pkg::word_t last_wr_addr,
    output cache_pkg::line_t last_wr_line
);
    import cache_pkg::*;

    // Lines written back so far by line address
    line_t store [word_t];
    int    delay;
    word_t addr;

    // Untouched memory holds a scrambled copy of each word address
    function automatic line_t fill_line(word_t line_addr);
        line_t l;
        for (int i = 0; i < 8; i++) begin
            l[32*i +: 32] = ((line_addr + word_t'(4 * i)) * 32'h9e37_79b1) ^ 32'h5a3c_0f69;
        end
        return l;
    endfunction

    initial begin
        mem_rdata    = '0;
        mem_resp     = 1'b0;
        write_count  = 0;
        last_wr_addr = '0;
        last_wr_line = '0;
        forever begin
            @(negedge clk);
            if (mem_read || mem_write) begin
                delay = int'($urandom_range(5, 2));
                repeat (delay - 1) @(negedge clk);
                @(posedge clk);
                #2;
                addr = {mem_addr[31:5], 5'b0};
                if (mem_write) begin
                    store[addr]  = mem_wdata;
                    write_count  = write_count + 1;
                    last_wr_addr = addr;
                    last_wr_line = mem_wdata;
                end else begin
                    mem_rdata = store.exists(addr) ? store[addr] : fill_line(addr);
                end
                // One-cycle response
                mem_resp = 1'b1;
                @(posedge clk);
                #2;
                mem_resp = 1'b0;
            end
        end
    end

endmodule
